/* logic/csr_access_ctrl.sv */
`default_nettype none

module csr_access_ctrl import csr_pkg::*; (
	input  logic                  csr_access_i,
	input  logic [CSR_ADDR_W-1:0] csr_addr_i,
	input  csr_op_e               csr_op_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic                  instr_commit_i,
	input  priv_lvl_e             priv_lvl_i,
	output logic [XLEN-1:0]       csr_rdata_o,
	output logic                  illegal_o,
	csr_bus_if.ctrl               trap_bus,
	csr_bus_if.ctrl               irq_bus,
	csr_bus_if.ctrl               cnt_bus
);

	logic [XLEN-1:0] rdata;
	logic [XLEN-1:0] wdata;
	logic            no_hit;
	logic            priv_fail;
	logic            ro_write;
	logic            wreq;
	logic            we;

	// Units return zero when they miss, so a plain OR merges them.
	assign rdata  = trap_bus.rdata | irq_bus.rdata | cnt_bus.rdata;
	assign no_hit = ~(trap_bus.hit | irq_bus.hit | cnt_bus.hit);

	assign wreq      = (csr_op_i != CSR_OP_READ);
	assign priv_fail = (csr_addr_i[9:8] > priv_lvl_i);          // Minimum privilege field.
	assign ro_write  = (csr_addr_i[11:10] == 2'b11) && wreq;    // Read-only range.
	assign illegal_o = csr_access_i & (no_hit | priv_fail | ro_write);

	// Set and clear are read-modify-write on the merged read data.
	always_comb begin
		case (csr_op_i)
			CSR_OP_WRITE: wdata = csr_wdata_i;
			CSR_OP_SET:   wdata = csr_wdata_i | rdata;
			CSR_OP_CLEAR: wdata = rdata & ~csr_wdata_i;
			default:      wdata = csr_wdata_i;
		endcase
	end

	assign we = csr_access_i & instr_commit_i & wreq & ~illegal_o;

	assign csr_rdata_o = rdata;

	assign trap_bus.addr  = csr_addr_i;
	assign trap_bus.wdata = wdata;
	assign trap_bus.we    = we;

	assign irq_bus.addr  = csr_addr_i;
	assign irq_bus.wdata = wdata;
	assign irq_bus.we    = we;

	assign cnt_bus.addr  = csr_addr_i;
	assign cnt_bus.wdata = wdata;
	assign cnt_bus.we    = we;

endmodule

`default_nettype wire

/* logic/csr_bus_if.sv */
`default_nettype none

interface csr_bus_if import csr_pkg::*; ();

	// Controller side.
	logic [CSR_ADDR_W-1:0] addr;
	logic [XLEN-1:0]       wdata;
	logic                  we;    // Same strobe goes to every unit.

	// Unit side.
	logic [XLEN-1:0]       rdata; // Zero unless the unit hits.
	logic                  hit;

	modport ctrl (
		output addr,
		output wdata,
		output we,
		input  rdata,
		input  hit
	);

	modport unit (
		input  addr,
		input  wdata,
		input  we,
		output rdata,
		output hit
	);

endinterface

`default_nettype wire

/* logic/csr_file.sv */
`default_nettype none

module csr_file import csr_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_ni,

	input  logic                  csr_access_i,
	input  logic [CSR_ADDR_W-1:0] csr_addr_i,
	input  logic [1:0]            csr_op_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic                  instr_commit_i,
	output logic [XLEN-1:0]       csr_rdata_o,
	output logic                  illegal_csr_insn_o,

	input  logic                  irq_software_i,
	input  logic                  irq_timer_i,
	input  logic                  irq_external_i,
	output logic [NUM_IRQS-1:0]   irqs_o,
	output logic                  irq_pending_o,

	input  logic                  csr_mtvec_init_i,
	input  logic [XLEN-1:0]       boot_addr_i,
	input  logic [XLEN-1:0]       pc_id_i,
	input  logic                  csr_save_cause_i,
	input  logic [CAUSE_W-1:0]    csr_mcause_i,
	input  logic [XLEN-1:0]       csr_mtval_i,
	input  logic                  csr_restore_mret_i,

	input  logic                  instr_ret_i,

	output logic [1:0]            priv_mode_o,
	output logic                  csr_mstatus_mie_o,
	output logic                  csr_mstatus_tw_o,
	output logic [XLEN-1:0]       csr_mepc_o,
	output logic [XLEN-1:0]       csr_mtvec_o
);

	csr_op_e   csr_op;
	priv_lvl_e priv_lvl;

	csr_bus_if trap_bus ();
	csr_bus_if irq_bus ();
	csr_bus_if cnt_bus ();

	assign csr_op      = csr_op_e'(csr_op_i);
	assign priv_mode_o = priv_lvl;

	csr_access_ctrl u_access_ctrl (
		.csr_access_i   (csr_access_i),
		.csr_addr_i     (csr_addr_i),
		.csr_op_i       (csr_op),
		.csr_wdata_i    (csr_wdata_i),
		.instr_commit_i (instr_commit_i),
		.priv_lvl_i     (priv_lvl),
		.csr_rdata_o    (csr_rdata_o),
		.illegal_o      (illegal_csr_insn_o),
		.trap_bus       (trap_bus.ctrl),
		.irq_bus        (irq_bus.ctrl),
		.cnt_bus        (cnt_bus.ctrl)
	);

	csr_trap_regs u_trap_regs (
		.clk_i              (clk_i),
		.rst_ni             (rst_ni),
		.bus                (trap_bus.unit),
		.csr_mtvec_init_i   (csr_mtvec_init_i),
		.boot_addr_i        (boot_addr_i),
		.pc_id_i            (pc_id_i),
		.csr_save_cause_i   (csr_save_cause_i),
		.csr_mcause_i       (csr_mcause_i),
		.csr_mtval_i        (csr_mtval_i),
		.csr_restore_mret_i (csr_restore_mret_i),
		.priv_lvl_o         (priv_lvl),
		.mstatus_mie_o      (csr_mstatus_mie_o),
		.mstatus_tw_o       (csr_mstatus_tw_o),
		.mepc_o             (csr_mepc_o),
		.mtvec_o            (csr_mtvec_o)
	);

	csr_irq_regs u_irq_regs (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.bus            (irq_bus.unit),
		.irq_software_i (irq_software_i),
		.irq_timer_i    (irq_timer_i),
		.irq_external_i (irq_external_i),
		.irqs_o         (irqs_o),
		.irq_pending_o  (irq_pending_o)
	);

	csr_perf_counters u_perf_counters (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.bus         (cnt_bus.unit),
		.instr_ret_i (instr_ret_i)
	);

endmodule

`default_nettype wire

/* logic/csr_irq_regs.sv */
`default_nettype none

module csr_irq_regs import csr_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_ni,
	csr_bus_if.unit             bus,
	input  logic                irq_software_i,
	input  logic                irq_timer_i,
	input  logic                irq_external_i,
	output logic [NUM_IRQS-1:0] irqs_o,
	output logic                irq_pending_o
);

	// Both vectors are ordered {software, timer, external}.
	logic [NUM_IRQS-1:0] mie_q;
	logic [NUM_IRQS-1:0] mip;

	function automatic logic [XLEN-1:0] irq_to_csr(input logic [NUM_IRQS-1:0] v);
		logic [XLEN-1:0] r;
		r = '0;
		r[IRQ_MSI_BIT] = v[2];
		r[IRQ_MTI_BIT] = v[1];
		r[IRQ_MEI_BIT] = v[0];
		return r;
	endfunction

	assign mip = {irq_software_i, irq_timer_i, irq_external_i}; // Live inputs.

	always_comb begin
		bus.rdata = '0;
		bus.hit   = 1'b1;
		case (bus.addr)
			CSR_MIE: bus.rdata = irq_to_csr(mie_q);
			CSR_MIP: bus.rdata = irq_to_csr(mip); // Writes land nowhere.
			default: bus.hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mie_q <= '0;
		end else if (bus.we && (bus.addr == CSR_MIE)) begin
			mie_q <= {bus.wdata[IRQ_MSI_BIT], bus.wdata[IRQ_MTI_BIT], bus.wdata[IRQ_MEI_BIT]};
		end
	end

	// The core gates these with mstatus.MIE.
	assign irqs_o        = mip & mie_q;
	assign irq_pending_o = |irqs_o;

endmodule

`default_nettype wire

/* logic/csr_perf_counters.sv */
`default_nettype none

module csr_perf_counters import csr_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_ni,
	csr_bus_if.unit bus,
	input  logic    instr_ret_i
);

	logic [CNT_W-1:0]   cnt_q [NUM_CNT];
	logic [CNT_W-1:0]   cnt_d [NUM_CNT];
	logic [NUM_CNT-1:0] inhibit_q;
	logic [NUM_CNT-1:0] cnt_event;
	logic [NUM_CNT-1:0] hit_lo;
	logic [NUM_CNT-1:0] hit_hi;
	logic               inhibit_hit;

	// Same order as CNT_IDX.
	assign cnt_event   = {instr_ret_i, 1'b1};
	assign inhibit_hit = (bus.addr == CSR_MCOUNTINHIBIT);

	// Counter index is also the offset from mcycle and mcycleh.
	always_comb begin
		for (int i = 0; i < NUM_CNT; i++) begin
			hit_lo[i] = (bus.addr == CSR_ADDR_W'(CSR_MCYCLE + CNT_IDX[i]));
			hit_hi[i] = (bus.addr == CSR_ADDR_W'(CSR_MCYCLEH + CNT_IDX[i]));
		end
	end

	always_comb begin
		bus.rdata = '0;
		if (inhibit_hit) begin
			for (int i = 0; i < NUM_CNT; i++) begin
				bus.rdata[CNT_IDX[i]] = inhibit_q[i]; // Other bits read 0.
			end
		end
		for (int i = 0; i < NUM_CNT; i++) begin
			if (hit_lo[i]) begin
				bus.rdata = cnt_q[i][XLEN-1:0];
			end
			if (hit_hi[i]) begin
				bus.rdata = cnt_q[i][CNT_W-1:XLEN];
			end
		end
		bus.hit = inhibit_hit | (|hit_lo) | (|hit_hi);
	end

	// A write replaces that cycle's increment.
	always_comb begin
		for (int i = 0; i < NUM_CNT; i++) begin
			cnt_d[i] = cnt_q[i];
			if (bus.we && hit_lo[i]) begin
				cnt_d[i][XLEN-1:0] = bus.wdata;
			end else if (bus.we && hit_hi[i]) begin
				cnt_d[i][CNT_W-1:XLEN] = bus.wdata;
			end else if (cnt_event[i] && !inhibit_q[i]) begin
				cnt_d[i] = cnt_q[i] + CNT_W'(1);
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < NUM_CNT; i++) begin
				cnt_q[i] <= '0;
			end
			inhibit_q <= '0;
		end else begin
			for (int i = 0; i < NUM_CNT; i++) begin
				cnt_q[i] <= cnt_d[i];
			end
			if (bus.we && inhibit_hit) begin
				for (int i = 0; i < NUM_CNT; i++) begin
					inhibit_q[i] <= bus.wdata[CNT_IDX[i]];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/csr_pkg.sv */
`default_nettype none

package csr_pkg;

	localparam int unsigned XLEN       = 32;
	localparam int unsigned CSR_ADDR_W = 12;
	localparam int unsigned CNT_W      = 64;

	typedef enum logic [CSR_ADDR_W-1:0] {
		CSR_MSTATUS       = 12'h300,
		CSR_MIE           = 12'h304,
		CSR_MTVEC         = 12'h305,
		CSR_MCOUNTINHIBIT = 12'h320,
		CSR_MSCRATCH      = 12'h340,
		CSR_MEPC          = 12'h341,
		CSR_MCAUSE        = 12'h342,
		CSR_MTVAL         = 12'h343,
		CSR_MIP           = 12'h344,
		CSR_MCYCLE        = 12'hB00,
		CSR_MINSTRET      = 12'hB02,
		CSR_MCYCLEH       = 12'hB80,
		CSR_MINSTRETH     = 12'hB82
	} csr_addr_e;

	typedef enum logic [1:0] {
		CSR_OP_READ  = 2'd0,
		CSR_OP_WRITE = 2'd1,
		CSR_OP_SET   = 2'd2,
		CSR_OP_CLEAR = 2'd3
	} csr_op_e;

	typedef enum logic [1:0] {
		PRIV_LVL_U = 2'b00,
		PRIV_LVL_M = 2'b11
	} priv_lvl_e;

	// mstatus fields.
	localparam int unsigned MSTATUS_MIE_BIT  = 3;
	localparam int unsigned MSTATUS_MPIE_BIT = 7;
	localparam int unsigned MSTATUS_MPP_LO   = 11; // Two bits wide.
	localparam int unsigned MSTATUS_TW_BIT   = 21;

	// mie and mip bit positions.
	localparam int unsigned IRQ_MSI_BIT = 3;
	localparam int unsigned IRQ_MTI_BIT = 7;
	localparam int unsigned IRQ_MEI_BIT = 11;
	localparam int unsigned NUM_IRQS    = 3;

	localparam int unsigned CAUSE_W = 6; // Interrupt flag and 5-bit code.

	localparam logic [1:0]  MTVEC_MODE_VECTORED = 2'b01;
	localparam int unsigned MTVEC_ALIGN_LO      = 2; // Bits 7:2 read as zero.
	localparam int unsigned MTVEC_ALIGN_HI      = 7;

	// Counter indices double as mcountinhibit bits and address offsets.
	localparam int unsigned CNT_CYCLE   = 0;
	localparam int unsigned CNT_INSTRET = 2;
	localparam int unsigned NUM_CNT     = 2;
	localparam int unsigned CNT_IDX [NUM_CNT] = '{CNT_CYCLE, CNT_INSTRET};

	// Reset values.
	localparam logic            MSTATUS_MPIE_RST = 1'b1;
	localparam logic [XLEN-1:0] MTVEC_RST = {{(XLEN-2){1'b0}}, MTVEC_MODE_VECTORED};

endpackage

`default_nettype wire

/* logic/csr_trap_regs.sv */
`default_nettype none

module csr_trap_regs import csr_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_ni,
	csr_bus_if.unit            bus,
	input  logic               csr_mtvec_init_i,
	input  logic [XLEN-1:0]    boot_addr_i,
	input  logic [XLEN-1:0]    pc_id_i,
	input  logic               csr_save_cause_i,
	input  logic [CAUSE_W-1:0] csr_mcause_i,
	input  logic [XLEN-1:0]    csr_mtval_i,
	input  logic               csr_restore_mret_i,
	output priv_lvl_e          priv_lvl_o,
	output logic               mstatus_mie_o,
	output logic               mstatus_tw_o,
	output logic [XLEN-1:0]    mepc_o,
	output logic [XLEN-1:0]    mtvec_o
);

	priv_lvl_e          priv_lvl_q, priv_lvl_d;
	logic               mie_q, mie_d;
	logic               mpie_q, mpie_d;
	priv_lvl_e          mpp_q, mpp_d;
	logic               tw_q, tw_d;
	logic [XLEN-1:0]    mscratch_q, mscratch_d;
	logic [XLEN-1:0]    mepc_q, mepc_d;
	logic [CAUSE_W-1:0] mcause_q, mcause_d;
	logic [XLEN-1:0]    mtval_q, mtval_d;
	logic [XLEN-1:0]    mtvec_q, mtvec_d;

	// Base from bits 31:8, vectored mode.
	function automatic logic [XLEN-1:0] mtvec_base(input logic [XLEN-1:0] addr);
		return {addr[XLEN-1:MTVEC_ALIGN_HI+1],
			{(MTVEC_ALIGN_HI - MTVEC_ALIGN_LO + 1){1'b0}}, MTVEC_MODE_VECTORED};
	endfunction

	always_comb begin
		bus.rdata = '0;
		bus.hit   = 1'b1;
		case (bus.addr)
			CSR_MSTATUS: begin
				bus.rdata[MSTATUS_MIE_BIT]       = mie_q;
				bus.rdata[MSTATUS_MPIE_BIT]      = mpie_q;
				bus.rdata[MSTATUS_MPP_LO +: 2]   = mpp_q;
				bus.rdata[MSTATUS_TW_BIT]        = tw_q;
			end
			CSR_MSCRATCH: bus.rdata = mscratch_q;
			CSR_MEPC:     bus.rdata = mepc_q;
			CSR_MCAUSE:   bus.rdata = {mcause_q[CAUSE_W-1], {(XLEN-CAUSE_W){1'b0}},
				mcause_q[CAUSE_W-2:0]};
			CSR_MTVAL:    bus.rdata = mtval_q;
			CSR_MTVEC:    bus.rdata = mtvec_q;
			default:      bus.hit = 1'b0;
		endcase
	end

	always_comb begin
		priv_lvl_d = priv_lvl_q;
		mie_d      = mie_q;
		mpie_d     = mpie_q;
		mpp_d      = mpp_q;
		tw_d       = tw_q;
		mscratch_d = mscratch_q;
		mepc_d     = mepc_q;
		mcause_d   = mcause_q;
		mtval_d    = mtval_q;
		mtvec_d    = csr_mtvec_init_i ? mtvec_base(boot_addr_i) : mtvec_q;

		if (bus.we) begin
			case (bus.addr)
				CSR_MSTATUS: begin
					mie_d  = bus.wdata[MSTATUS_MIE_BIT];
					mpie_d = bus.wdata[MSTATUS_MPIE_BIT];
					// Only U and M exist; anything else maps to M.
					mpp_d  = (bus.wdata[MSTATUS_MPP_LO +: 2] == PRIV_LVL_U) ?
						PRIV_LVL_U : PRIV_LVL_M;
					tw_d   = bus.wdata[MSTATUS_TW_BIT];
				end
				CSR_MSCRATCH: mscratch_d = bus.wdata;
				CSR_MEPC:     mepc_d = {bus.wdata[XLEN-1:1], 1'b0};
				CSR_MCAUSE:   mcause_d = {bus.wdata[XLEN-1], bus.wdata[CAUSE_W-2:0]};
				CSR_MTVAL:    mtval_d = bus.wdata;
				CSR_MTVEC:    mtvec_d = mtvec_base(bus.wdata);
				default: ;
			endcase
		end

		if (csr_save_cause_i) begin // Trap entry wins over mret.
			priv_lvl_d = PRIV_LVL_M;
			mpie_d     = mie_q;
			mie_d      = 1'b0;
			mpp_d      = priv_lvl_q;
			mepc_d     = pc_id_i;
			mcause_d   = csr_mcause_i;
			mtval_d    = csr_mtval_i;
		end else if (csr_restore_mret_i) begin
			priv_lvl_d = mpp_q;
			mie_d      = mpie_q;
			mpie_d     = 1'b1;
			mpp_d      = PRIV_LVL_U;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			priv_lvl_q <= PRIV_LVL_M;
			mie_q      <= 1'b0;
			mpie_q     <= MSTATUS_MPIE_RST;
			mpp_q      <= PRIV_LVL_U;
			tw_q       <= 1'b0;
			mscratch_q <= '0;
			mepc_q     <= '0;
			mcause_q   <= '0;
			mtval_q    <= '0;
			mtvec_q    <= MTVEC_RST;
		end else begin
			priv_lvl_q <= priv_lvl_d;
			mie_q      <= mie_d;
			mpie_q     <= mpie_d;
			mpp_q      <= mpp_d;
			tw_q       <= tw_d;
			mscratch_q <= mscratch_d;
			mepc_q     <= mepc_d;
			mcause_q   <= mcause_d;
			mtval_q    <= mtval_d;
			mtvec_q    <= mtvec_d;
		end
	end

	assign priv_lvl_o    = priv_lvl_q;
	assign mstatus_mie_o = mie_q;
	assign mstatus_tw_o  = tw_q;
	assign mepc_o        = mepc_q;
	assign mtvec_o       = mtvec_q;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_csr_file -o tb_csr_file

out=$(./obj_dir/tb_csr_file)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi

/* sim.f */
logic/csr_pkg.sv
logic/csr_bus_if.sv
logic/csr_access_ctrl.sv
logic/csr_trap_regs.sv
logic/csr_irq_regs.sv
logic/csr_perf_counters.sv
logic/csr_file.sv
test/csr_checker.sv
test/tb_csr_file.sv

/* test/csr_checker.sv */
`default_nettype none

module csr_checker import csr_pkg::*; (
	input wire [XLEN-1:0]     rdata_i,
	input wire                illegal_i,
	input wire [NUM_IRQS-1:0] irqs_i,
	input wire                pending_i,
	input wire [1:0]          priv_i,
	input wire [XLEN-1:0]     mepc_i,
	input wire [XLEN-1:0]     mtvec_i,
	input wire                mie_i,
	input wire                tw_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned error_cnt    = 0;
	int unsigned test_errors  = 0;
	int unsigned tests_run    = 0;
	int unsigned tests_failed = 0;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			error_cnt++;
			test_errors++;
		end
	endtask

	task automatic rdata_is(input logic [XLEN-1:0] exp);
		compare("csr_rdata_o", rdata_i, exp);
	endtask

	task automatic illegal_is(input logic exp);
		compare("illegal_csr_insn_o", {31'b0, illegal_i}, {31'b0, exp});
	endtask

	task automatic priv_is(input logic [1:0] exp);
		compare("priv_mode_o", {30'b0, priv_i}, {30'b0, exp});
	endtask

	// Pending is the OR of the enabled interrupts.
	task automatic irqs_are(input logic [NUM_IRQS-1:0] exp);
		compare("irqs_o", {29'b0, irqs_i}, {29'b0, exp});
		compare("irq_pending_o", {31'b0, pending_i}, {31'b0, |exp});
	endtask

	task automatic mepc_is(input logic [XLEN-1:0] exp);
		compare("csr_mepc_o", mepc_i, exp);
	endtask

	task automatic mtvec_is(input logic [XLEN-1:0] exp);
		compare("csr_mtvec_o", mtvec_i, exp);
	endtask

	task automatic mstatus_out_is(input logic mie, input logic tw);
		compare("csr_mstatus_mie_o", {31'b0, mie_i}, {31'b0, mie});
		compare("csr_mstatus_tw_o", {31'b0, tw_i}, {31'b0, tw});
	endtask

	task automatic value_is(input string name, input logic [31:0] got, input logic [31:0] exp);
		compare(name, got, exp);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %-18s PASS", name);
		end else begin
			$display("Test %-18s FAIL (%0d mismatches)", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic summarize();
		$display("%0d tests run, %0d failed, %0d mismatches in total",
			tests_run, tests_failed, error_cnt);
	endtask

endmodule

`default_nettype wire

/* test/tb_csr_file.sv */
`default_nettype none

module tb_csr_file import csr_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// Rough cycle budget of each test.
	localparam int unsigned TEST_CYCLES = 8 + 30 + 10 + 16 + 26 + 60;
	localparam int unsigned CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic clk_i = 1'b0;
	logic rst_ni;
	logic csr_access_i, instr_commit_i;
	logic [CSR_ADDR_W-1:0] csr_addr_i;
	logic [1:0] csr_op_i;
	logic [XLEN-1:0] csr_wdata_i, csr_rdata_o;
	logic illegal_csr_insn_o;
	logic irq_software_i, irq_timer_i, irq_external_i, irq_pending_o;
	logic [NUM_IRQS-1:0] irqs_o;
	logic csr_mtvec_init_i, csr_save_cause_i, csr_restore_mret_i, instr_ret_i;
	logic [XLEN-1:0] boot_addr_i, pc_id_i, csr_mtval_i;
	logic [CAUSE_W-1:0] csr_mcause_i;
	logic [1:0] priv_mode_o;
	logic csr_mstatus_mie_o, csr_mstatus_tw_o;
	logic [XLEN-1:0] csr_mepc_o, csr_mtvec_o;
	int unsigned cycle_cnt = 0;

	csr_file DUT (.*);

	csr_checker u_checker (
		.rdata_i   (csr_rdata_o),
		.illegal_i (illegal_csr_insn_o),
		.irqs_i    (irqs_o),
		.pending_i (irq_pending_o),
		.priv_i    (priv_mode_o),
		.mepc_i    (csr_mepc_o),
		.mtvec_i   (csr_mtvec_o),
		.mie_i     (csr_mstatus_mie_o),
		.tw_i      (csr_mstatus_tw_o)
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// Expected register value after a legal write.
	function automatic logic [XLEN-1:0] ref_csr_write(input logic [CSR_ADDR_W-1:0] addr,
			input csr_op_e op, input logic [XLEN-1:0] old, input logic [XLEN-1:0] wdata);
		logic [XLEN-1:0] v;
		logic [XLEN-1:0] r;
		case (op)
			CSR_OP_WRITE: v = wdata;
			CSR_OP_SET:   v = old | wdata;
			CSR_OP_CLEAR: v = old & ~wdata;
			default:      v = old;
		endcase
		r = '0;
		case (addr)
			CSR_MEPC:  v[0] = 1'b0;
			CSR_MTVEC: v = {v[31:8], 6'b0, 2'b01};
			CSR_MCAUSE: v = {v[31], 26'b0, v[4:0]};
			CSR_MSTATUS: begin
				r[3]     = v[3];
				r[7]     = v[7];
				r[12:11] = (v[12:11] == 2'b00) ? 2'b00 : 2'b11; // Only U or M.
				r[21]    = v[21];
				v        = r;
			end
			default: ;
		endcase
		return v;
	endfunction

	task automatic access(input logic [CSR_ADDR_W-1:0] addr, input csr_op_e op,
			input logic [XLEN-1:0] wdata, input logic commit);
		@(posedge clk_i);
		csr_access_i   <= 1'b1;
		csr_addr_i     <= addr;
		csr_op_i       <= op;
		csr_wdata_i    <= wdata;
		instr_commit_i <= commit;
		@(negedge clk_i); // Combinational results are settled here.
	endtask

	task automatic read_expect(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] exp);
		access(addr, CSR_OP_READ, '0, 1'b0);
		u_checker.rdata_is(exp);
	endtask

	task automatic idle(input int unsigned n);
		repeat (n) begin
			@(posedge clk_i);
			csr_access_i   <= 1'b0;
			instr_commit_i <= 1'b0;
		end
	endtask

	task automatic trap_enter(input logic [XLEN-1:0] pc, input logic [CAUSE_W-1:0] cause,
			input logic [XLEN-1:0] tval);
		idle(1);
		csr_save_cause_i <= 1'b1;
		pc_id_i          <= pc;
		csr_mcause_i     <= cause;
		csr_mtval_i      <= tval;
		@(posedge clk_i);
		csr_save_cause_i <= 1'b0;
	endtask

	logic [CSR_ADDR_W-1:0] addr_tab [3] = '{CSR_MSCRATCH, CSR_MEPC, CSR_MTVEC};
	logic [XLEN-1:0] model [3] = '{32'h0, 32'h0, 32'h1};
	logic [XLEN-1:0] ms, w, e, a, b, pc, tval;
	logic [CAUSE_W-1:0] cause;
	logic [1:0] idx;
	logic [2:0] m, v;
	csr_op_e op;
	int unsigned n, seed_ret;

	initial begin
		seed_ret = $urandom(91614);
		rst_ni = 1'b0;
		csr_access_i = 1'b0;
		instr_commit_i = 1'b0;
		csr_addr_i = '0;
		csr_op_i = '0;
		csr_wdata_i = '0;
		// All raised, so only the reset value of mie keeps irqs_o low.
		{irq_software_i, irq_timer_i, irq_external_i} = 3'b111;
		csr_mtvec_init_i = 1'b0;
		csr_save_cause_i = 1'b0;
		csr_restore_mret_i = 1'b0;
		instr_ret_i = 1'b0;
		boot_addr_i = '0;
		pc_id_i = '0;
		csr_mtval_i = '0;
		csr_mcause_i = '0;
		repeat (3) @(posedge clk_i);
		rst_ni <= 1'b1;

		read_expect(CSR_MSTATUS, 32'h80);
		read_expect(CSR_MTVEC, 32'h1);
		u_checker.mtvec_is(32'h1);
		u_checker.mstatus_out_is(1'b0, 1'b0);
		u_checker.priv_is(2'b11);
		u_checker.irqs_are(3'b000);
		u_checker.finish_test("reset values");

		repeat (12) begin
			idx = 2'($urandom_range(2, 0));
			op  = csr_op_e'(2'($urandom_range(3, 1)));
			w   = $urandom;
			model[idx] = ref_csr_write(addr_tab[idx], op, model[idx], w);
			access(addr_tab[idx], op, w, 1'b1);
			u_checker.illegal_is(1'b0);
			read_expect(addr_tab[idx], model[idx]);
			u_checker.mepc_is(model[1]);
			u_checker.mtvec_is(model[2]);
		end
		access(CSR_MSCRATCH, CSR_OP_WRITE, ~model[0], 1'b0); // Not committed.
		read_expect(CSR_MSCRATCH, model[0]);
		u_checker.finish_test("access operations");

		access(12'h301, CSR_OP_READ, '0, 1'b0);
		u_checker.illegal_is(1'b1);
		access(12'hF14, CSR_OP_READ, '0, 1'b0);
		u_checker.illegal_is(1'b1);
		access(12'h7B0, CSR_OP_WRITE, $urandom, 1'b1);
		u_checker.illegal_is(1'b1);
		access(12'hC00, CSR_OP_WRITE, $urandom, 1'b1);
		u_checker.illegal_is(1'b1);
		read_expect(CSR_MSCRATCH, model[0]);
		read_expect(CSR_MEPC, model[1]);
		u_checker.finish_test("illegal accesses");

		access(CSR_MSTATUS, CSR_OP_WRITE, 32'h200008, 1'b1);
		ms = ref_csr_write(CSR_MSTATUS, CSR_OP_WRITE, 32'h80, 32'h200008);
		pc    = $urandom;
		cause = 6'($urandom);
		tval  = $urandom;
		trap_enter(pc, cause, tval);
		ms[7]     = ms[3];
		ms[3]     = 1'b0;
		ms[12:11] = 2'b11;
		read_expect(CSR_MEPC, pc);
		read_expect(CSR_MCAUSE, {cause[5], 26'b0, cause[4:0]});
		read_expect(CSR_MTVAL, tval);
		read_expect(CSR_MSTATUS, ms);
		u_checker.mstatus_out_is(ms[3], ms[21]);
		u_checker.mepc_is(pc);
		u_checker.priv_is(2'b11);
		access(CSR_MSTATUS, CSR_OP_CLEAR, 32'h1800, 1'b1);
		ms = ref_csr_write(CSR_MSTATUS, CSR_OP_CLEAR, ms, 32'h1800);
		read_expect(CSR_MSTATUS, ms);
		idle(1);
		csr_restore_mret_i <= 1'b1;
		@(posedge clk_i);
		csr_restore_mret_i <= 1'b0;
		@(negedge clk_i);
		u_checker.priv_is(ms[12:11]);
		u_checker.mstatus_out_is(ms[7], ms[21]); // MIE takes MPIE.
		access(CSR_MSCRATCH, CSR_OP_WRITE, ~model[0], 1'b1);
		u_checker.illegal_is(1'b1); // Machine CSR from U mode.
		trap_enter(pc, cause, tval);
		@(negedge clk_i);
		u_checker.priv_is(2'b11);
		read_expect(CSR_MSCRATCH, model[0]);
		u_checker.finish_test("trap and mret");

		repeat (8) begin
			w = $urandom;
			m = w[2:0];
			v = w[5:3];
			w[3]  = m[2];
			w[7]  = m[1];
			w[11] = m[0];
			access(CSR_MIE, CSR_OP_WRITE, w, 1'b1);
			idle(1);
			{irq_software_i, irq_timer_i, irq_external_i} <= v;
			e = '0;
			e[3]  = v[2];
			e[7]  = v[1];
			e[11] = v[0];
			read_expect(CSR_MIP, e);
			u_checker.irqs_are(m & v);
		end
		u_checker.finish_test("interrupts");

		access(CSR_MCYCLE, CSR_OP_READ, '0, 1'b0);
		a = csr_rdata_o;
		n = $urandom_range(15, 5);
		idle(n);
		access(CSR_MCYCLE, CSR_OP_READ, '0, 1'b0);
		b = csr_rdata_o;
		u_checker.value_is("mcycle delta", b - a, 32'(n + 1)); // n idle edges plus the read.
		access(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h1, 1'b1);
		read_expect(CSR_MCOUNTINHIBIT, 32'h1);
		access(CSR_MCYCLE, CSR_OP_READ, '0, 1'b0);
		a = csr_rdata_o;
		idle(4);
		access(CSR_MCYCLE, CSR_OP_READ, '0, 1'b0);
		u_checker.value_is("mcycle inhibited", csr_rdata_o, a);
		w = $urandom;
		access(CSR_MCYCLEH, CSR_OP_WRITE, w, 1'b1);
		read_expect(CSR_MCYCLEH, w);
		access(CSR_MINSTRET, CSR_OP_READ, '0, 1'b0);
		a = csr_rdata_o;
		n = $urandom_range(8, 1);
		repeat (n) begin
			idle(1);
			instr_ret_i <= 1'b1;
			@(posedge clk_i);
			instr_ret_i <= 1'b0;
		end
		access(CSR_MINSTRET, CSR_OP_READ, '0, 1'b0);
		u_checker.value_is("minstret delta", csr_rdata_o - a, n);
		u_checker.finish_test("counters");

		idle(1);
		u_checker.summarize();
		if (u_checker.error_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
